// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_la_top
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
la_pkg.sv
la_cmd_decoder.sv
la_sample_buf.sv
la_ctrl.sv
la_tx_serializer.sv
la_top.sv
tb_la_top.sv

// File: la_cmd_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module la_cmd_decoder (
  input  logic            clk_i,
  input  logic            rst_in,     // sync, active low
  input  logic            cmd_req_i,  // host request
  input  la_pkg::la_cmd_t cmd_i,      // held stable while req is high
  output logic            cmd_ack_o,
  output logic            set_cnt_o,  // one-cycle pulse
  output logic            run_o       // one-cycle pulse
);

  logic new_cmd;

  // request seen with ack still low starts a new transfer
  assign new_cmd = cmd_req_i && !cmd_ack_o;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      cmd_ack_o <= 1'b0;
      set_cnt_o <= 1'b0;
      run_o     <= 1'b0;
    end else begin
      // pulses come out together with the rising ack
      set_cnt_o <= new_cmd && (cmd_i.op == la_pkg::OP_SET_CNT);
      run_o     <= new_cmd && (cmd_i.op == la_pkg::OP_RUN);
      if (new_cmd) begin
        cmd_ack_o <= 1'b1;
      end else if (!cmd_req_i) begin
        cmd_ack_o <= 1'b0;  // host released req
      end
    end
  end

  // a single opcode never yields both pulses
  property p_one_pulse;
    @(posedge clk_i) disable iff (!rst_in)
      !(set_cnt_o && run_o);
  endproperty
  a_one_pulse : assert property (p_one_pulse)
    else $error("set_cnt_o and run_o high together");

endmodule

`default_nettype wire

// File: la_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module la_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_in,
  input  logic                         set_cnt_i,  // load counts from cmd_i
  input  la_pkg::la_cmd_t              cmd_i,
  input  logic                         run_i,      // arm trigger
  input  logic                         stb_i,      // sample strobe
  input  logic                         tx_rdy_i,   // serializer idle
  output logic                         wrt_o,
  output logic                         rewind_o,
  output logic [la_pkg::CNT_WIDTH-1:0] rd_cnt_o,
  output logic                         read_o,
  output logic                         tx_stb_o,
  output logic                         busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    TRIG,
    READ,
    TX_WAIT
  } state_e;

  state_e state;
  state_e state_next;

  logic [la_pkg::CNT_WIDTH-1:0] cnt;
  logic [la_pkg::CNT_WIDTH-1:0] cnt_next;
  logic [la_pkg::CNT_WIDTH-1:0] dly_cnt;
  logic [la_pkg::CNT_WIDTH-1:0] rd_cnt;

  assign rd_cnt_o = rd_cnt;
  assign busy_o   = (state != IDLE);

  always_comb begin
    state_next = state;
    cnt_next   = cnt;
    wrt_o      = 1'b0;
    rewind_o   = 1'b0;
    read_o     = 1'b0;
    tx_stb_o   = 1'b0;

    case (state)
      IDLE: begin
        wrt_o = stb_i;  // pre-trigger samples fill the ring
        if (run_i) begin
          state_next = TRIG;
          cnt_next   = '0;
        end
      end

      TRIG: begin
        if (stb_i) begin
          wrt_o    = 1'b1;
          cnt_next = cnt + 1'b1;
        end else if (cnt == dly_cnt) begin
          state_next = READ;
          rewind_o   = 1'b1;
          cnt_next   = '0;  // reused as readout count
        end
      end

      READ: begin
        if (cnt == rd_cnt) begin
          state_next = IDLE;
        end else if (tx_rdy_i) begin
          read_o     = 1'b1;
          tx_stb_o   = 1'b1;  // serializer picks q_o up next cycle
          cnt_next   = cnt + 1'b1;
          state_next = TX_WAIT;
        end
      end

      TX_WAIT: begin
        if (tx_rdy_i) begin
          state_next = READ;
        end
      end

      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      cnt   <= cnt_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      dly_cnt <= la_pkg::CNT_WIDTH'(1);
      rd_cnt  <= la_pkg::CNT_WIDTH'(1);
    end else if (set_cnt_i) begin
      dly_cnt <= cmd_i.dly_cnt;
      rd_cnt  <= cmd_i.rd_cnt;
    end
  end

  property p_read_in_read;
    @(posedge clk_i) disable iff (!rst_in)
      read_o |-> (state == READ) ##1 (state == TX_WAIT);
  endproperty
  a_read_in_read : assert property (p_read_in_read)
    else $error("read_o outside READ");

  // serializer must be free whenever a sample is handed over
  property p_stb_when_rdy;
    @(posedge clk_i) disable iff (!rst_in)
      tx_stb_o |-> tx_rdy_i;
  endproperty
  a_stb_when_rdy : assert property (p_stb_when_rdy)
    else $error("tx_stb_o while serializer busy");

endmodule

`default_nettype wire

// File: la_pkg.sv
`default_nettype none

package la_pkg;

  // width of each count field in a command word
  localparam int CNT_WIDTH = 8;

  typedef enum logic [1:0] {
    OP_NOP     = 2'd0,  // acknowledged, no action
    OP_SET_CNT = 2'd1,  // load delay and readout counts
    OP_RUN     = 2'd2   // arm capture
  } la_op_e;

  // one word of the command port, 18 bits
  typedef struct packed {
    la_op_e                 op;       // opcode in the top bits
    logic [CNT_WIDTH-1:0]   dly_cnt;  // samples after trigger
    logic [CNT_WIDTH-1:0]   rd_cnt;   // samples to read back
  } la_cmd_t;

endpackage

`default_nettype wire

// File: la_sample_buf.sv
`default_nettype none
`timescale 1ns/10ps

module la_sample_buf #(
  parameter int SMPL_WIDTH = 16,
  parameter int DEPTH_LOG2 = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_in,
  input  logic                         wrt_i,     // store d_i at write pointer
  input  logic [SMPL_WIDTH-1:0]        d_i,
  input  logic                         rewind_i,  // move read pointer behind write
  input  logic [la_pkg::CNT_WIDTH-1:0] rd_cnt_i,
  input  logic                         read_i,    // fetch word into q_o
  output logic [SMPL_WIDTH-1:0]        q_o
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  logic [SMPL_WIDTH-1:0] mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;

  // pointers wrap naturally at DEPTH
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wrt_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rewind_i) begin
        // oldest of the newest rd_cnt entries
        rd_ptr <= wr_ptr - DEPTH_LOG2'(rd_cnt_i);
      end else if (read_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wrt_i) begin
      mem[wr_ptr] <= d_i;
    end
  end

  // registered read port, data one cycle after read_i
  always_ff @(posedge clk_i) begin
    if (read_i) begin
      q_o <= mem[rd_ptr];
    end
  end

  // the controller never captures while reading back
  property p_no_rw_overlap;
    @(posedge clk_i) disable iff (!rst_in)
      !(read_i && wrt_i);
  endproperty
  a_no_rw_overlap : assert property (p_no_rw_overlap)
    else $error("read_i and wrt_i high in the same cycle");

endmodule

`default_nettype wire

// File: la_top.sv
`default_nettype none
`timescale 1ns/10ps

module la_top #(
  parameter int SMPL_WIDTH = 16,
  parameter int TX_WIDTH   = 8,
  parameter int DEPTH_LOG2 = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_in,
  input  logic                  cmd_req_i,
  input  la_pkg::la_cmd_t       cmd_i,
  output logic                  cmd_ack_o,
  input  logic                  smpl_stb_i,
  input  logic [SMPL_WIDTH-1:0] smpl_i,
  output logic                  tx_req_o,
  input  logic                  tx_ack_i,
  output logic [TX_WIDTH-1:0]   tx_o,
  output logic                  busy_o
);

  logic                         set_cnt;
  logic                         run;
  logic                         wrt;
  logic                         rewind;
  logic [la_pkg::CNT_WIDTH-1:0] rd_cnt;
  logic                         read;
  logic [SMPL_WIDTH-1:0]        buf_q;    // read data, one cycle after read
  logic                         tx_stb;
  logic                         tx_rdy;

  la_cmd_decoder la_cmd_decoder_i (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .cmd_req_i (cmd_req_i),
    .cmd_i     (cmd_i),
    .cmd_ack_o (cmd_ack_o),
    .set_cnt_o (set_cnt),
    .run_o     (run)
  );

  la_ctrl la_ctrl_i (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .set_cnt_i (set_cnt),
    .cmd_i     (cmd_i),      // still held by the host during the pulse
    .run_i     (run),
    .stb_i     (smpl_stb_i),
    .tx_rdy_i  (tx_rdy),
    .wrt_o     (wrt),
    .rewind_o  (rewind),
    .rd_cnt_o  (rd_cnt),
    .read_o    (read),
    .tx_stb_o  (tx_stb),
    .busy_o    (busy_o)
  );

  la_sample_buf #(
    .SMPL_WIDTH (SMPL_WIDTH),
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) la_sample_buf_i (
    .clk_i    (clk_i),
    .rst_in   (rst_in),
    .wrt_i    (wrt),
    .d_i      (smpl_i),
    .rewind_i (rewind),
    .rd_cnt_i (rd_cnt),
    .read_i   (read),
    .q_o      (buf_q)
  );

  la_tx_serializer #(
    .SMPL_WIDTH (SMPL_WIDTH),
    .TX_WIDTH   (TX_WIDTH)
  ) la_tx_serializer_i (
    .clk_i    (clk_i),
    .rst_in   (rst_in),
    .stb_i    (tx_stb),
    .d_i      (buf_q),
    .tx_rdy_o (tx_rdy),
    .tx_req_o (tx_req_o),
    .tx_ack_i (tx_ack_i),
    .tx_o     (tx_o)
  );

endmodule

`default_nettype wire

// File: la_tx_serializer.sv
`default_nettype none
`timescale 1ns/10ps

module la_tx_serializer #(
  parameter int SMPL_WIDTH = 16,
  parameter int TX_WIDTH   = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_in,
  input  logic                  stb_i,     // sample arrives on d_i next cycle
  input  logic [SMPL_WIDTH-1:0] d_i,
  output logic                  tx_rdy_o,
  output logic                  tx_req_o,
  input  logic                  tx_ack_i,
  output logic [TX_WIDTH-1:0]   tx_o
);

  localparam int N_WORDS = SMPL_WIDTH / TX_WIDTH;
  localparam int WCNT_W  = $clog2(N_WORDS + 1);

  typedef enum logic [1:0] {
    P_IDLE,
    P_LOAD,     // wait one cycle for buffer data
    P_REQ,      // req high, waiting for ack
    P_ACK_LOW   // req low, waiting for ack release
  } phase_e;

  phase_e                phase;
  logic [SMPL_WIDTH-1:0] shreg;
  logic [WCNT_W-1:0]     words_left;

  assign tx_rdy_o = (phase == P_IDLE);
  assign tx_o     = shreg[SMPL_WIDTH-1 -: TX_WIDTH];  // msb word first

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      phase      <= P_IDLE;
      tx_req_o   <= 1'b0;
      words_left <= '0;
    end else begin
      case (phase)
        P_IDLE: begin
          if (stb_i) begin
            phase <= P_LOAD;
          end
        end
        P_LOAD: begin
          words_left <= WCNT_W'(N_WORDS - 1);
          tx_req_o   <= 1'b1;
          phase      <= P_REQ;
        end
        P_REQ: begin
          if (tx_ack_i) begin
            tx_req_o <= 1'b0;
            phase    <= P_ACK_LOW;
          end
        end
        P_ACK_LOW: begin
          if (!tx_ack_i) begin
            if (words_left == '0) begin
              phase <= P_IDLE;  // whole sample delivered
            end else begin
              words_left <= words_left - 1'b1;
              tx_req_o   <= 1'b1;
              phase      <= P_REQ;
            end
          end
        end
        default: phase <= P_IDLE;
      endcase
    end
  end

  // data path, shifted only while req is low
  always_ff @(posedge clk_i) begin
    if (phase == P_LOAD) begin
      shreg <= d_i;
    end else if (phase == P_ACK_LOW && !tx_ack_i && words_left != '0) begin
      shreg <= shreg << TX_WIDTH;
    end
  end

  property p_tx_stable;
    @(posedge clk_i) disable iff (!rst_in)
      (tx_req_o && $past(tx_req_o)) |-> $stable(tx_o);
  endproperty
  a_tx_stable : assert property (p_tx_stable)
    else $error("tx_o changed while tx_req_o high");

endmodule

`default_nettype wire

// File: tb_la_top.sv
`default_nettype none
`timescale 1ns/10ps

module tb_la_top;

  localparam int SMPL_WIDTH = 16;
  localparam int TX_WIDTH   = 8;
  localparam int N_WORDS    = SMPL_WIDTH / TX_WIDTH;
  localparam int N_ROWS     = 5;
  localparam int TIMEOUT    = 2000;  // cycles per wait

  typedef struct packed {
    logic [7:0] dly;       // post-trigger samples
    logic [7:0] rd;        // samples read back
    logic [8:0] pre;       // pre-trigger samples
    logic       run_busy;  // extra RUN during readout
  } row_t;

  logic                  clk_i;
  logic                  rst_in;
  logic                  cmd_req_i;
  la_pkg::la_cmd_t       cmd_i;
  logic                  cmd_ack_o;
  logic                  smpl_stb_i;
  logic [SMPL_WIDTH-1:0] smpl_i;
  logic                  tx_req_o;
  logic                  tx_ack_i;
  logic [TX_WIDTH-1:0]   tx_o;
  logic                  busy_o;

  row_t                  rows [N_ROWS];
  logic [SMPL_WIDTH-1:0] captured [$];  // every sample written to the ring
  logic [TX_WIDTH-1:0]   exp_words [$];
  logic [TX_WIDTH-1:0]   got_words [$];
  int                    errors;
  int unsigned           smpl_idx;
  int                    r;

  la_top #(
    .SMPL_WIDTH (SMPL_WIDTH),
    .TX_WIDTH   (TX_WIDTH),
    .DEPTH_LOG2 (8)
  ) la_top_i (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .cmd_req_i  (cmd_req_i),
    .cmd_i      (cmd_i),
    .cmd_ack_o  (cmd_ack_o),
    .smpl_stb_i (smpl_stb_i),
    .smpl_i     (smpl_i),
    .tx_req_o   (tx_req_o),
    .tx_ack_i   (tx_ack_i),
    .tx_o       (tx_o),
    .busy_o     (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    $display("errors: %0d", errors);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic wait_cmd_ack(input logic level);
    int n;
    n = 0;
    @(negedge clk_i);
    while (cmd_ack_o !== level) begin
      n++;
      if (n > TIMEOUT) abort_run(level ? "cmd_ack_o to rise" : "cmd_ack_o to fall");
      @(negedge clk_i);
    end
  endtask

  // one full four-phase command transfer
  task automatic send_cmd(input la_pkg::la_op_e op, input logic [7:0] dly, input logic [7:0] rd);
    la_pkg::la_cmd_t c;
    c.op      = op;
    c.dly_cnt = dly;
    c.rd_cnt  = rd;
    @(posedge clk_i);
    cmd_i     <= c;
    cmd_req_i <= 1'b1;
    @(negedge clk_i);
    check("cmd_ack_o", 32'(cmd_ack_o), 32'h0);  // req not yet seen
    wait_cmd_ack(1'b1);
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    @(negedge clk_i);
    check("cmd_ack_o", 32'(cmd_ack_o), 32'h1);  // held until req seen low
    wait_cmd_ack(1'b0);
  endtask

  task automatic strobe_samples(input int n);
    logic [SMPL_WIDTH-1:0] v;
    int i;
    for (i = 0; i < n; i++) begin
      repeat ($urandom_range(0, 2)) @(posedge clk_i);  // gap between strobes
      v = SMPL_WIDTH'(smpl_idx * 32'h9e37);
      smpl_idx++;
      @(posedge clk_i);
      smpl_stb_i <= 1'b1;
      smpl_i     <= v;
      captured.push_back(v);
      @(posedge clk_i);
      smpl_stb_i <= 1'b0;
    end
  endtask

  // newest rd samples, oldest first, msb word first
  task automatic build_expected(input int rd);
    logic [SMPL_WIDTH-1:0] v;
    int i;
    int w;
    exp_words.delete();
    for (i = captured.size() - rd; i < captured.size(); i++) begin
      v = captured[i];
      for (w = N_WORDS - 1; w >= 0; w--) begin
        exp_words.push_back(TX_WIDTH'(v >> (w * TX_WIDTH)));
      end
    end
  endtask

  // host side of the transmit handshake with random ack delays
  task automatic collect_tx();
    logic [TX_WIDTH-1:0] w;
    int n;
    got_words.delete();
    n = 0;
    @(negedge clk_i);
    while (busy_o || tx_req_o) begin
      if (tx_req_o) begin
        w = tx_o;
        repeat ($urandom_range(0, 4)) begin
          @(negedge clk_i);
          check("tx_o", 32'(tx_o), 32'(w));
        end
        @(posedge clk_i);
        tx_ack_i <= 1'b1;
        n = 0;
        @(negedge clk_i);
        while (tx_req_o) begin
          check("tx_o", 32'(tx_o), 32'(w));
          n++;
          if (n > TIMEOUT) abort_run("tx_req_o to fall");
          @(negedge clk_i);
        end
        got_words.push_back(w);
        repeat ($urandom_range(0, 3)) @(posedge clk_i);
        @(posedge clk_i);
        tx_ack_i <= 1'b0;
        n = 0;
      end else begin
        n++;
        if (n > TIMEOUT) abort_run("a tx word or busy_o to fall");
      end
      @(negedge clk_i);
    end
  endtask

  task automatic compare_words();
    int i;
    check("tx word count", 32'(got_words.size()), 32'(exp_words.size()));
    for (i = 0; i < got_words.size() && i < exp_words.size(); i++) begin
      check("tx_o", 32'(got_words[i]), 32'(exp_words[i]));
    end
  endtask

  initial begin
    void'($urandom(32'ha21c1f3b));
    errors     = 0;
    smpl_idx   = 0;
    rst_in     = 1'b0;
    cmd_req_i  = 1'b0;
    cmd_i      = '0;
    smpl_stb_i = 1'b0;
    smpl_i     = '0;
    tx_ack_i   = 1'b0;
    rows[0] = '{8'd4,   8'd6,  9'd5,  1'b0};
    rows[1] = '{8'd3,   8'd0,  9'd2,  1'b0};  // empty readout
    rows[2] = '{8'd10,  8'd12, 9'd3,  1'b1};
    rows[3] = '{8'd240, 8'd30, 9'd10, 1'b0};  // readout crosses the ring end
    rows[4] = '{8'd0,   8'd5,  9'd4,  1'b0};
    repeat (5) @(posedge clk_i);
    rst_in <= 1'b1;
    @(negedge clk_i);
    check("cmd_ack_o", 32'(cmd_ack_o), 32'h0);
    check("tx_req_o", 32'(tx_req_o), 32'h0);
    check("busy_o", 32'(busy_o), 32'h0);
    send_cmd(la_pkg::OP_NOP, 8'h00, 8'h00);
    for (r = 0; r < N_ROWS; r++) begin
      send_cmd(la_pkg::OP_SET_CNT, rows[r].dly, rows[r].rd);
      strobe_samples(int'(rows[r].pre));
      send_cmd(la_pkg::OP_RUN, 8'h00, 8'h00);
      strobe_samples(int'(rows[r].dly));
      build_expected(int'(rows[r].rd));
      if (rows[r].run_busy) begin
        fork
          collect_tx();
          begin
            repeat (3) @(posedge clk_i);
            send_cmd(la_pkg::OP_RUN, 8'hff, 8'hff);
            @(negedge clk_i);
            check("busy_o", 32'(busy_o), 32'h1);  // readout still running
          end
        join
      end else begin
        collect_tx();
      end
      compare_words();
      @(negedge clk_i);
      check("busy_o", 32'(busy_o), 32'h0);  // no re-arm after readout
      check("tx_req_o", 32'(tx_req_o), 32'h0);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
